//--- common/rate_change_pkg.sv
/* Shared types for the rate change subsystem. The header is a 64-bit stand-in for CHDR
   and only its eob, SID and length fields are rewritten on the way out */
`default_nettype none

package rate_change_pkg;

  localparam int HDR_W = 64;

  // Packet header carried on the tuser side channel
  typedef struct packed {
    logic [1:0]  pkt_type;
    logic        eob;       // Last packet of a burst
    logic [12:0] seqnum;
    logic [15:0] src_sid;
    logic [15:0] dst_sid;
    logic [15:0] length;    // Payload words in this packet
  } pkt_hdr_t;

  // Word addresses on the settings bus
  typedef enum logic [1:0] {
    ADDR_RATE     = 2'd0,
    ADDR_CONFIG   = 2'd1,
    ADDR_PKT_SIZE = 2'd2,
    ADDR_SID      = 2'd3
  } reg_addr_e;

  // Bit positions in the config register
  localparam int CFG_INJECT_ZEROS = 0;
  localparam int CFG_CLEAR_EOB    = 1;

  typedef enum logic {
    DEC_ACCUM,  // Collecting samples of a group
    DEC_EMIT    // Sum is waiting to be accepted
  } dec_state_e;

endpackage

`default_nettype wire

//--- common/sample_stream_if.sv
/* Valid/ready sample stream. Data and flags must hold while tvalid is high
   and tready is low */
`timescale 1ns/1ns
`default_nettype none

interface sample_stream_if #(
  parameter int WIDTH = 16
) ();

  logic [WIDTH-1:0] tdata;
  logic             tlast;
  logic             teob;   // Marks the end of a burst, qualified by tlast
  logic             tvalid;
  logic             tready;

  modport src (output tdata, tlast, teob, tvalid, input tready);
  modport snk (input tdata, tlast, teob, tvalid, output tready);

endinterface

`default_nettype wire

//--- src/rate_change_regs.sv
/* Wishbone classic settings slave, one-cycle ack. A packet size of 0 after reset
   stalls the datapath until software writes it */
`timescale 1ns/1ns
`default_nettype none

module rate_change_regs import rate_change_pkg::*; #(
  parameter int MAX_RATE     = 8,
  parameter int MAX_PKT_SIZE = 64
) (
  input  logic                              clk,
  input  logic                              i_arst_n,
  input  logic                              i_wb_cyc,
  input  logic                              i_wb_stb,
  input  logic                              i_wb_we,
  input  logic [1:0]                        i_wb_adr,
  input  logic [31:0]                       i_wb_dat,
  output logic [31:0]                       o_wb_dat,
  output logic                              o_wb_ack,
  output logic [$clog2(MAX_RATE+1)-1:0]     o_rate,
  output logic                              o_inject_zeros,
  output logic                              o_clear_eob_en,
  output logic [$clog2(MAX_PKT_SIZE+1)-1:0] o_pkt_size,
  output logic [15:0]                       o_src_sid,
  output logic [15:0]                       o_dst_sid
);

  localparam int RATE_W = $clog2(MAX_RATE + 1);
  localparam int SIZE_W = $clog2(MAX_PKT_SIZE + 1);

  logic        wb_req;
  reg_addr_e   addr;
  logic [1:0]  cfg_q;
  logic [31:0] sid_q;
  logic [31:0] rdata;

  assign wb_req = i_wb_cyc & i_wb_stb & ~o_wb_ack;  // Ack drops for a cycle between requests
  assign addr   = reg_addr_e'(i_wb_adr);

  assign o_inject_zeros = cfg_q[CFG_INJECT_ZEROS];
  assign o_clear_eob_en = cfg_q[CFG_CLEAR_EOB];
  assign o_src_sid      = sid_q[31:16];
  assign o_dst_sid      = sid_q[15:0];

  always_comb begin
    case (addr)
      ADDR_RATE:     rdata = 32'(o_rate);
      ADDR_CONFIG:   rdata = {30'd0, cfg_q};
      ADDR_PKT_SIZE: rdata = 32'(o_pkt_size);
      default:       rdata = sid_q;
    endcase
  end

  always_ff @(posedge clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      o_wb_ack   <= 1'b0;
      o_rate     <= RATE_W'(1);  // No rate change by default
      cfg_q      <= 2'b00;
      o_pkt_size <= '0;
      sid_q      <= '0;
    end else begin
      o_wb_ack <= wb_req;
      if (wb_req && i_wb_we) begin
        case (addr)
          ADDR_RATE:     o_rate     <= i_wb_dat[RATE_W-1:0];
          ADDR_CONFIG:   cfg_q      <= i_wb_dat[1:0];
          ADDR_PKT_SIZE: o_pkt_size <= i_wb_dat[SIZE_W-1:0];
          default:       sid_q      <= i_wb_dat;
        endcase
      end
    end
  end

  always_ff @(posedge clk) begin
    if (wb_req) o_wb_dat <= rdata;  // Old contents are returned when reading a written word
  end

  a_ack_single: assert property (@(posedge clk) disable iff (!i_arst_n)
    o_wb_ack |=> !o_wb_ack);

endmodule

`default_nettype wire

//--- rate_change/header_fifo.sv
/* Header FIFO between the adapter input and the resizer. The writer must not
   push while full */
`timescale 1ns/1ns
`default_nettype none

module header_fifo import rate_change_pkg::*; #(
  parameter int HEADER_FIFO_DEPTH = 4
) (
  input  logic     clk,
  input  logic     i_arst_n,
  input  logic     i_clear,
  input  pkt_hdr_t i_hdr,
  input  logic     i_push,
  output logic     o_full,
  output pkt_hdr_t o_hdr,
  output logic     o_pop_ready,
  input  logic     i_pop
);

  localparam int PTR_W = (HEADER_FIFO_DEPTH > 1) ? $clog2(HEADER_FIFO_DEPTH) : 1;
  localparam logic [PTR_W-1:0] LAST_PTR = PTR_W'(HEADER_FIFO_DEPTH - 1);

  logic [HDR_W-1:0] mem [HEADER_FIFO_DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [PTR_W:0]   count;

  assign o_full      = (count == (PTR_W+1)'(HEADER_FIFO_DEPTH));
  assign o_pop_ready = (count != '0);
  assign o_hdr       = pkt_hdr_t'(mem[rd_ptr]);

  always_ff @(posedge clk) begin
    if (i_push) mem[wr_ptr] <= i_hdr;
  end

  always_ff @(posedge clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else if (i_clear) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (i_push) wr_ptr <= (wr_ptr == LAST_PTR) ? '0 : wr_ptr + 1'b1;
      if (i_pop)  rd_ptr <= (rd_ptr == LAST_PTR) ? '0 : rd_ptr + 1'b1;
      if (i_push && !i_pop)      count <= count + 1'b1;
      else if (i_pop && !i_push) count <= count - 1'b1;
    end
  end

  a_no_overflow:  assert property (@(posedge clk) disable iff (!i_arst_n) !(i_push && o_full));
  a_no_underflow: assert property (@(posedge clk) disable iff (!i_arst_n)
    !(i_pop && !o_pop_ready));

endmodule

`default_nettype wire

//--- rate_change/rate_change_adapter.sv
/* Decimating side of the rate adapter. Bursts must hold a multiple of N packets
   unless zero injection is on, and input packets must be P samples long */
`timescale 1ns/1ns
`default_nettype none

module rate_change_adapter import rate_change_pkg::*; #(
  parameter int WIDTH             = 16,
  parameter int MAX_RATE          = 8,
  parameter int HEADER_FIFO_DEPTH = 4
) (
  input  logic                          clk,
  input  logic                          i_arst_n,
  input  logic                          i_clear,
  input  logic [$clog2(MAX_RATE+1)-1:0] i_rate,
  input  logic                          i_inject_zeros,
  input  logic                          i_clear_eob_en,
  input  logic [15:0]                   i_src_sid,
  input  logic [15:0]                   i_dst_sid,
  input  logic [WIDTH-1:0]              i_tdata,
  input  logic                          i_tlast,
  input  logic                          i_tvalid,
  output logic                          o_tready,
  input  pkt_hdr_t                      i_tuser,
  sample_stream_if.src                  to_user,
  sample_stream_if.snk                  from_user,
  output logic [WIDTH-1:0]              o_data,
  output logic                          o_last,
  output logic                          o_eob,
  output logic                          o_valid,
  input  logic                          i_ready,
  output pkt_hdr_t                      o_hdr,
  input  logic                          i_hdr_pop,
  output logic                          o_clear_eob
);

  localparam int RATE_W = $clog2(MAX_RATE + 1);

  logic              first_line;  // Next input word opens a packet
  logic [RATE_W-1:0] pkt_cnt;     // Packet index within the current group of N
  logic              inject;
  logic              need_push;
  logic              hdr_full;
  logic              hdr_avail;
  logic              hdr_stall;
  logic              in_xfer;
  logic              in_eob_xfer;
  logic              user_xfer;
  logic              user_eob_xfer;
  pkt_hdr_t          fifo_hdr;

  assign need_push   = first_line & (pkt_cnt == '0);
  assign hdr_stall   = need_push & hdr_full;  // Hold the group opener until the FIFO has room
  assign in_xfer     = i_tvalid & o_tready;
  assign in_eob_xfer = in_xfer & i_tlast & i_tuser.eob;

  // While injecting, zeros replace the input and the input is held off
  assign to_user.tdata  = inject ? '0 : i_tdata;
  assign to_user.tlast  = inject ? 1'b0 : i_tlast;
  assign to_user.teob   = inject ? 1'b0 : i_tuser.eob;
  assign to_user.tvalid = inject | (i_tvalid & ~o_clear_eob & ~hdr_stall);
  assign o_tready       = ~inject & to_user.tready & ~o_clear_eob & ~hdr_stall;

  // Output side only moves when a header is waiting for it
  assign from_user.tready = i_ready & hdr_avail & ~o_clear_eob;
  assign o_valid          = from_user.tvalid & hdr_avail & ~o_clear_eob;
  assign o_data           = from_user.tdata;
  assign o_last           = from_user.tlast;
  assign o_eob            = from_user.teob;
  assign user_xfer        = from_user.tvalid & from_user.tready;
  assign user_eob_xfer    = user_xfer & from_user.tlast & from_user.teob;

  always_comb begin
    o_hdr         = fifo_hdr;
    o_hdr.eob     = from_user.teob;
    o_hdr.src_sid = i_src_sid;
    o_hdr.dst_sid = i_dst_sid;
  end

  always_ff @(posedge clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      first_line  <= 1'b1;
      pkt_cnt     <= '0;
      inject      <= 1'b0;
      o_clear_eob <= 1'b0;
    end else if (i_clear) begin
      first_line  <= 1'b1;
      pkt_cnt     <= '0;
      inject      <= 1'b0;
      o_clear_eob <= 1'b0;
    end else begin
      if (in_xfer) first_line <= i_tlast;
      if (in_eob_xfer) begin
        pkt_cnt <= '0;  // Next burst opens a fresh group
        inject  <= i_inject_zeros;
      end else if (in_xfer && first_line) begin
        pkt_cnt <= (pkt_cnt + 1'b1 >= i_rate) ? '0 : pkt_cnt + 1'b1;
      end
      if (user_eob_xfer) inject <= 1'b0;  // Partial group has been flushed out
      o_clear_eob <= user_eob_xfer & i_clear_eob_en;
    end
  end

  header_fifo #(
    .HEADER_FIFO_DEPTH(HEADER_FIFO_DEPTH)
  ) u_header_fifo (
    .clk        (clk),
    .i_arst_n   (i_arst_n),
    .i_clear    (i_clear),
    .i_hdr      (i_tuser),
    .i_push     (in_xfer & need_push),
    .o_full     (hdr_full),
    .o_hdr      (fifo_hdr),
    .o_pop_ready(hdr_avail),
    .i_pop      (i_hdr_pop)
  );

  // A group's header is queued with its first sample, before any of its sums exist
  a_hdr_before_data: assert property (@(posedge clk) disable iff (!i_arst_n)
    from_user.tvalid |-> hdr_avail);
  // The resizer may only release a header on a word that left the user block
  a_pop_on_xfer: assert property (@(posedge clk) disable iff (!i_arst_n)
    i_hdr_pop |-> user_xfer);

endmodule

`default_nettype wire

//--- src/boxcar_decimator.sv
/* Boxcar decimator, sums each group of i_rate samples and wraps at WIDTH bits.
   A rate of 0 behaves as 1 */
`timescale 1ns/1ns
`default_nettype none

module boxcar_decimator import rate_change_pkg::*; #(
  parameter int WIDTH    = 16,
  parameter int MAX_RATE = 8
) (
  input  logic                          clk,
  input  logic                          i_arst_n,
  input  logic                          i_clear,
  input  logic [$clog2(MAX_RATE+1)-1:0] i_rate,
  sample_stream_if.snk                  in,
  sample_stream_if.src                  out
);

  localparam int RATE_W = $clog2(MAX_RATE + 1);
  localparam int ACC_W  = WIDTH + $clog2(MAX_RATE);

  dec_state_e        state;
  logic [RATE_W-1:0] cnt;
  logic [ACC_W-1:0]  acc;
  logic              grp_eob;  // Some sample of this group closed a burst
  logic              in_xfer;

  assign in_xfer    = in.tvalid & in.tready;
  assign in.tready  = (state == DEC_ACCUM);  // No new samples while a sum is pending
  assign out.tvalid = (state == DEC_EMIT);
  assign out.tdata  = acc[WIDTH-1:0];
  assign out.tlast  = grp_eob;
  assign out.teob   = grp_eob;

  always_ff @(posedge clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      state   <= DEC_ACCUM;
      cnt     <= '0;
      acc     <= '0;
      grp_eob <= 1'b0;
    end else if (i_clear) begin
      state   <= DEC_ACCUM;
      cnt     <= '0;
      acc     <= '0;
      grp_eob <= 1'b0;
    end else begin
      case (state)
        DEC_ACCUM: begin
          if (in_xfer) begin
            acc     <= acc + ACC_W'(in.tdata);
            grp_eob <= grp_eob | (in.tlast & in.teob);
            if (cnt + 1'b1 >= i_rate) begin
              cnt   <= '0;
              state <= DEC_EMIT;
            end else begin
              cnt <= cnt + 1'b1;
            end
          end
        end
        default: begin
          if (out.tready) begin
            state   <= DEC_ACCUM;
            acc     <= '0;
            grp_eob <= 1'b0;
          end
        end
      endcase
    end
  end

  a_hold_output: assert property (@(posedge clk) disable iff (!i_arst_n || i_clear)
    out.tvalid && !out.tready |=> out.tvalid && $stable(out.tdata));

endmodule

`default_nettype wire

//--- src/packet_resizer.sv
/* Cuts the decimated stream into packets of i_pkt_size words, shorter at end of burst.
   o_tuser length is only meaningful on the tlast word */
`timescale 1ns/1ns
`default_nettype none

module packet_resizer import rate_change_pkg::*; #(
  parameter int WIDTH        = 16,
  parameter int MAX_PKT_SIZE = 64
) (
  input  logic                              clk,
  input  logic                              i_arst_n,
  input  logic                              i_clear,
  input  logic [$clog2(MAX_PKT_SIZE+1)-1:0] i_pkt_size,
  input  logic [WIDTH-1:0]                  i_data,
  input  logic                              i_last,
  input  logic                              i_eob,
  input  logic                              i_valid,
  output logic                              o_ready,
  input  pkt_hdr_t                          i_hdr,
  output logic                              o_hdr_pop,
  output logic [WIDTH-1:0]                  o_tdata,
  output logic                              o_tlast,
  output logic                              o_tvalid,
  input  logic                              i_o_tready,
  output pkt_hdr_t                          o_tuser
);

  localparam int SIZE_W = $clog2(MAX_PKT_SIZE + 1);

  logic [SIZE_W-1:0] word_cnt;  // Position of the current word in its packet, from 1
  logic              size_ok;
  logic              xfer;

  assign size_ok   = (i_pkt_size != '0);  // An unprogrammed size holds the stream
  assign o_tdata   = i_data;
  assign o_tvalid  = i_valid & size_ok;
  assign o_ready   = i_o_tready & size_ok;
  assign o_tlast   = (word_cnt >= i_pkt_size) | (i_last & i_eob);
  assign xfer      = o_tvalid & i_o_tready;
  assign o_hdr_pop = xfer & o_tlast;

  always_comb begin
    o_tuser        = i_hdr;
    o_tuser.length = o_tlast ? 16'(word_cnt) : 16'(i_pkt_size);
  end

  always_ff @(posedge clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      word_cnt <= SIZE_W'(1);
    end else if (i_clear) begin
      word_cnt <= SIZE_W'(1);
    end else if (xfer) begin
      word_cnt <= o_tlast ? SIZE_W'(1) : word_cnt + 1'b1;
    end
  end

endmodule

`default_nettype wire

//--- src/rate_change_top.sv
/* Decimating rate change subsystem with a Wishbone settings port. Program the
   packet size before sending data, it resets to 0 */
`timescale 1ns/1ns
`default_nettype none

module rate_change_top import rate_change_pkg::*; #(
  parameter int WIDTH             = 16,
  parameter int MAX_RATE          = 8,
  parameter int MAX_PKT_SIZE      = 64,
  parameter int HEADER_FIFO_DEPTH = 4
) (
  input  logic             clk,
  input  logic             i_arst_n,
  input  logic             i_clear,
  input  logic             i_wb_cyc,
  input  logic             i_wb_stb,
  input  logic             i_wb_we,
  input  logic [1:0]       i_wb_adr,
  input  logic [31:0]      i_wb_dat,
  output logic [31:0]      o_wb_dat,
  output logic             o_wb_ack,
  input  logic [WIDTH-1:0] i_tdata,
  input  logic             i_tlast,
  input  logic             i_tvalid,
  output logic             o_tready,
  input  pkt_hdr_t         i_tuser,
  output logic [WIDTH-1:0] o_tdata,
  output logic             o_tlast,
  output logic             o_tvalid,
  input  logic             i_o_tready,
  output pkt_hdr_t         o_tuser,
  output logic             o_clear_eob
);

  logic [$clog2(MAX_RATE+1)-1:0]     rate;
  logic [$clog2(MAX_PKT_SIZE+1)-1:0] pkt_size;
  logic                              inject_zeros;
  logic                              clear_eob_en;
  logic [15:0]                       src_sid;
  logic [15:0]                       dst_sid;
  logic [WIDTH-1:0]                  rs_data;  // Adapter to resizer
  logic                              rs_last;
  logic                              rs_eob;
  logic                              rs_valid;
  logic                              rs_ready;
  logic                              hdr_pop;
  pkt_hdr_t                          rs_hdr;

  sample_stream_if #(.WIDTH(WIDTH)) to_user ();
  sample_stream_if #(.WIDTH(WIDTH)) from_user ();

  rate_change_regs #(.MAX_RATE(MAX_RATE), .MAX_PKT_SIZE(MAX_PKT_SIZE)) u_regs (
    .clk(clk), .i_arst_n(i_arst_n),
    .i_wb_cyc(i_wb_cyc), .i_wb_stb(i_wb_stb), .i_wb_we(i_wb_we),
    .i_wb_adr(i_wb_adr), .i_wb_dat(i_wb_dat), .o_wb_dat(o_wb_dat), .o_wb_ack(o_wb_ack),
    .o_rate(rate), .o_inject_zeros(inject_zeros), .o_clear_eob_en(clear_eob_en),
    .o_pkt_size(pkt_size), .o_src_sid(src_sid), .o_dst_sid(dst_sid)
  );

  rate_change_adapter #(
    .WIDTH(WIDTH), .MAX_RATE(MAX_RATE), .HEADER_FIFO_DEPTH(HEADER_FIFO_DEPTH)
  ) u_adapter (
    .clk(clk), .i_arst_n(i_arst_n), .i_clear(i_clear), .i_rate(rate),
    .i_inject_zeros(inject_zeros), .i_clear_eob_en(clear_eob_en),
    .i_src_sid(src_sid), .i_dst_sid(dst_sid),
    .i_tdata(i_tdata), .i_tlast(i_tlast), .i_tvalid(i_tvalid), .o_tready(o_tready),
    .i_tuser(i_tuser), .to_user(to_user.src), .from_user(from_user.snk),
    .o_data(rs_data), .o_last(rs_last), .o_eob(rs_eob), .o_valid(rs_valid),
    .i_ready(rs_ready), .o_hdr(rs_hdr), .i_hdr_pop(hdr_pop), .o_clear_eob(o_clear_eob)
  );

  boxcar_decimator #(.WIDTH(WIDTH), .MAX_RATE(MAX_RATE)) u_decimator (
    .clk(clk), .i_arst_n(i_arst_n), .i_clear(i_clear), .i_rate(rate),
    .in(to_user.snk), .out(from_user.src)
  );

  packet_resizer #(.WIDTH(WIDTH), .MAX_PKT_SIZE(MAX_PKT_SIZE)) u_resizer (
    .clk(clk), .i_arst_n(i_arst_n), .i_clear(i_clear), .i_pkt_size(pkt_size),
    .i_data(rs_data), .i_last(rs_last), .i_eob(rs_eob), .i_valid(rs_valid),
    .o_ready(rs_ready), .i_hdr(rs_hdr), .o_hdr_pop(hdr_pop),
    .o_tdata(o_tdata), .o_tlast(o_tlast), .o_tvalid(o_tvalid),
    .i_o_tready(i_o_tready), .o_tuser(o_tuser)
  );

endmodule

`default_nettype wire

//--- sim/rate_change_tb.sv
/* Testbench for rate_change_top. Input packets are always P samples long, and
   every burst ends with an eob packet */
`timescale 1ns/1ns
`default_nettype none

module rate_change_tb import rate_change_pkg::*;;

  localparam int WAIT_LIMIT = 1000;  // Cycles any single wait may take
  localparam logic [1:0] CLEAR_ONLY  = 2'(1 << CFG_CLEAR_EOB);
  localparam logic [1:0] INJECT_ONLY = 2'(1 << CFG_INJECT_ZEROS);
  localparam logic [1:0] INJECT_CLR  = CLEAR_ONLY | INJECT_ONLY;

  logic        clk;
  logic        i_arst_n;
  logic        i_clear;
  logic        i_wb_cyc;
  logic        i_wb_stb;
  logic        i_wb_we;
  logic [1:0]  i_wb_adr;
  logic [31:0] i_wb_dat;
  logic [31:0] o_wb_dat;
  logic        o_wb_ack;
  logic [15:0] i_tdata;
  logic        i_tlast;
  logic        i_tvalid;
  logic        o_tready;
  pkt_hdr_t    i_tuser;
  logic [15:0] o_tdata;
  logic        o_tlast;
  logic        o_tvalid;
  logic        i_o_tready;
  pkt_hdr_t    o_tuser;
  logic        o_clear_eob;

  int          errors;
  int          timeouts;
  int          seq;
  int          clear_pulses;
  logic        clear_prev;
  bit          random_ready;
  int          cur_rate;
  int          cur_size;
  bit          cur_inject;
  logic [31:0] cur_sid;

  // Expected output stream, filled by the reference model before a burst is sent
  logic [15:0] exp_data[$];
  bit          exp_last[$];
  pkt_hdr_t    exp_hdr[$];
  logic [15:0] want_data;
  bit          want_last;
  pkt_hdr_t    want_hdr;

  rate_change_top dut_i (
    .clk(clk), .i_arst_n(i_arst_n), .i_clear(i_clear),
    .i_wb_cyc(i_wb_cyc), .i_wb_stb(i_wb_stb), .i_wb_we(i_wb_we), .i_wb_adr(i_wb_adr),
    .i_wb_dat(i_wb_dat), .o_wb_dat(o_wb_dat), .o_wb_ack(o_wb_ack),
    .i_tdata(i_tdata), .i_tlast(i_tlast), .i_tvalid(i_tvalid), .o_tready(o_tready),
    .i_tuser(i_tuser), .o_tdata(o_tdata), .o_tlast(o_tlast), .o_tvalid(o_tvalid),
    .i_o_tready(i_o_tready), .o_tuser(o_tuser), .o_clear_eob(o_clear_eob)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // Groups of n packets share the header of their first packet, and each group of
  // n samples becomes one summed output word
  function automatic void expected_packets(input logic [15:0] samples[$],
                                           input pkt_hdr_t hdrs[$], input int n,
                                           input int p, input bit inject,
                                           input logic [31:0] sid);
    int          npk;
    int          first;
    int          k;
    int          nsamp;
    int          nout;
    int          o;
    int          s;
    logic [15:0] sum;
    pkt_hdr_t    h;
    npk = hdrs.size();
    for (first = 0; first < npk; first += n) begin
      k     = (npk - first < n) ? npk - first : n;
      nsamp = k * p;
      nout  = inject ? (nsamp + n - 1) / n : nsamp / n;  // Flushed tail counts as a word
      for (o = 0; o < nout; o++) begin
        sum = '0;
        for (s = o * n; s < (o + 1) * n && s < nsamp; s++) begin
          sum = sum + samples[first * p + s];
        end
        exp_data.push_back(sum);
        exp_last.push_back(o == nout - 1);
      end
      h         = hdrs[first];
      h.eob     = (first + k >= npk);
      h.src_sid = sid[31:16];
      h.dst_sid = sid[15:0];
      h.length  = 16'(nout);
      exp_hdr.push_back(h);
    end
  endfunction

  task automatic end_run();
    $display("Closing counts: %0d errors, %0d timeouts", errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  endtask

  task automatic bus_cycle(input logic we, input reg_addr_e adr, input logic [31:0] wdata,
                           output logic [31:0] rdata);
    int waited;
    waited = 0;
    @(posedge clk);
    i_wb_cyc <= 1'b1;
    i_wb_stb <= 1'b1;
    i_wb_we  <= we;
    i_wb_adr <= adr;
    i_wb_dat <= wdata;
    @(negedge clk);
    while (!o_wb_ack) begin
      waited++;
      if (waited > WAIT_LIMIT) begin
        $display("Timed out waiting for o_wb_ack");
        timeouts++;
        end_run();
      end
      @(negedge clk);
    end
    rdata = o_wb_dat;
    @(posedge clk);
    i_wb_cyc <= 1'b0;
    i_wb_stb <= 1'b0;
    i_wb_we  <= 1'b0;
    @(negedge clk);
    assert (!o_wb_ack) else begin
      errors++;
      $display("o_wb_ack stayed high for more than one cycle");
    end
  endtask

  task automatic write_reg(input reg_addr_e adr, input logic [31:0] data);
    logic [31:0] unused;
    bus_cycle(1'b1, adr, data, unused);
  endtask

  task automatic check_reg(input reg_addr_e adr, input logic [31:0] want);
    logic [31:0] got;
    bus_cycle(1'b0, adr, 32'd0, got);
    assert (got == want) else begin
      errors++;
      $display("error: o_wb_dat at address %h got %h expected %h", adr, got, want);
    end
  endtask

  task automatic program_regs(input int rate, input logic [1:0] cfg, input int size,
                              input logic [31:0] sid);
    write_reg(ADDR_RATE, 32'(rate));
    write_reg(ADDR_CONFIG, 32'(cfg));
    write_reg(ADDR_PKT_SIZE, 32'(size));
    write_reg(ADDR_SID, sid);
    check_reg(ADDR_RATE, 32'(rate));
    check_reg(ADDR_CONFIG, 32'(cfg));
    check_reg(ADDR_PKT_SIZE, 32'(size));
    check_reg(ADDR_SID, sid);
    cur_rate   = rate;
    cur_size   = size;
    cur_inject = cfg[CFG_INJECT_ZEROS];
    cur_sid    = sid;
  endtask

  // Starts on a rising edge and returns on the edge where the word was taken
  task automatic send_word(input logic [15:0] data, input logic last, input pkt_hdr_t hdr);
    int waited;
    waited = 0;
    i_tdata  <= data;
    i_tlast  <= last;
    i_tuser  <= hdr;
    i_tvalid <= 1'b1;
    @(negedge clk);
    while (!o_tready) begin
      waited++;
      if (waited > WAIT_LIMIT) begin
        $display("Timed out with the input stream stalled by o_tready");
        timeouts++;
        end_run();
      end
      @(negedge clk);
    end
    @(posedge clk);
  endtask

  task automatic send_burst(input int npk);
    logic [15:0] samples[$];
    pkt_hdr_t    hdrs[$];
    pkt_hdr_t    h;
    int          i;
    int          j;
    for (i = 0; i < npk; i++) begin
      h.pkt_type = 2'($urandom);
      h.eob      = (i == npk - 1);
      h.seqnum   = 13'(seq);
      h.src_sid  = 16'($urandom);  // Overwritten by the adapter
      h.dst_sid  = 16'($urandom);
      h.length   = 16'(cur_size);
      seq++;
      hdrs.push_back(h);
      for (j = 0; j < cur_size; j++) samples.push_back(16'($urandom));
    end
    expected_packets(samples, hdrs, cur_rate, cur_size, cur_inject, cur_sid);
    @(posedge clk);
    for (i = 0; i < npk; i++) begin
      for (j = 0; j < cur_size; j++) begin
        send_word(samples[i * cur_size + j], j == cur_size - 1, hdrs[i]);
      end
    end
    i_tvalid <= 1'b0;
  endtask

  task automatic finish_phase(input int want_pulses);
    int waited;
    waited = 0;
    while (exp_data.size() != 0) begin
      waited++;
      if (waited > WAIT_LIMIT) begin
        $display("Timed out with %0d output words still missing", exp_data.size());
        timeouts++;
        end_run();
      end
      @(negedge clk);
    end
    repeat (3) @(negedge clk);  // clear_eob follows the last word by one cycle
    assert (clear_pulses == want_pulses) else begin
      errors++;
      $display("error: o_clear_eob pulse count got %h expected %h", clear_pulses, want_pulses);
    end
    clear_pulses = 0;
  endtask

  initial begin
    i_o_tready = 1'b0;
    forever begin
      @(posedge clk);
      i_o_tready <= random_ready ? (($urandom % 4) != 0) : 1'b1;
    end
  end

  always @(negedge clk) begin
    if (i_arst_n && o_tvalid && i_o_tready) begin
      assert (exp_data.size() != 0) else begin
        errors++;
        $display("Output word %h arrived with none expected", o_tdata);
      end
      if (exp_data.size() != 0) begin
        want_data = exp_data.pop_front();
        want_last = exp_last.pop_front();
        assert (o_tdata == want_data) else begin
          errors++;
          $display("error: o_tdata got %h expected %h", o_tdata, want_data);
        end
        assert (o_tlast == want_last) else begin
          errors++;
          $display("error: o_tlast got %h expected %h", o_tlast, want_last);
        end
        if (want_last) begin
          want_hdr = exp_hdr.pop_front();
          assert (o_tuser == want_hdr) else begin
            errors++;
            $display("error: o_tuser got %h expected %h", o_tuser, want_hdr);
          end
        end
      end
    end
  end

  always @(negedge clk) begin
    if (i_arst_n) begin
      assert (!(o_clear_eob && clear_prev)) else begin
        errors++;
        $display("o_clear_eob stayed high for more than one cycle");
      end
      if (o_clear_eob) clear_pulses++;
      clear_prev = o_clear_eob;
    end
  end

  initial begin
    void'($urandom(32'h646c2ee0));
    errors       = 0;
    timeouts     = 0;
    seq          = 0;
    clear_pulses = 0;
    clear_prev   = 1'b0;
    random_ready = 1'b0;
    i_arst_n     = 1'b0;
    i_clear      = 1'b0;
    i_wb_cyc     = 1'b0;
    i_wb_stb     = 1'b0;
    i_wb_we      = 1'b0;
    i_wb_adr     = 2'd0;
    i_wb_dat     = 32'd0;
    i_tdata      = '0;
    i_tlast      = 1'b0;
    i_tvalid     = 1'b0;
    i_tuser      = '0;
    repeat (8) @(posedge clk);
    i_arst_n <= 1'b1;

    // Aligned bursts with full ready, one of them shorter than a group
    program_regs(4, CLEAR_ONLY, 8, 32'hA5C3_0F1E);
    send_burst(8);
    send_burst(2);
    finish_phase(2);

    // Rate 3 leaves a partial group that zeros must flush
    random_ready = 1'b1;
    program_regs(3, INJECT_ONLY, 8, 32'h1234_BEEF);
    send_burst(4);
    send_burst(3);
    send_burst(5);
    finish_phase(0);

    program_regs(4, INJECT_CLR, 6, 32'h0F0F_7001);
    send_burst(5);
    send_burst(3);
    finish_phase(2);

    end_run();
  end

endmodule

`default_nettype wire

//--- verilog.f
common/rate_change_pkg.sv
common/sample_stream_if.sv
src/rate_change_regs.sv
rate_change/header_fifo.sv
rate_change/rate_change_adapter.sv
src/boxcar_decimator.sv
src/packet_resizer.sv
src/rate_change_top.sv
sim/rate_change_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Builds the rate change testbench with Verilator, runs it and scans the log

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module rate_change_tb \
  -f verilog.f > build.log 2>&1 &&
  ./obj_dir/Vrate_change_tb > sim.log 2>&1 ;
cat build.log sim.log 2> /dev/null
[ -f sim.log ] &&
  ! grep -q "RESULT: FAIL" sim.log &&
  grep -q "RESULT: PASS" sim.log &&
  echo "Simulation passed" ||
  { echo "Simulation did not pass"; exit 1; }
